/* include/n64_ppu_settings.svh */
// N64 PPU settings
`ifndef N64_PPU_SETTINGS_SVH
`define N64_PPU_SETTINGS_SVH

// Video bus and pixel widths
`define N64_COLOR_W 7
`define OUT_COLOR_W 8
`define SYNC_W 4

// Sync nibble bit positions, active low
`define SYNC_VS_BIT 3
`define SYNC_HS_BIT 1

// AXI4-Lite bus
`define AXI_ADDR_W 4
`define AXI_DATA_W 32

// Register map
`define REG_CFG_ADDR 4'h0
`define REG_STAT_ADDR 4'h4

// Video info detection
`define LINE_CNT_W 10
`define PAL_MIN_LINES 10'd290

`endif

/* hdl/n64_ppu_pkg.sv */
// N64 PPU types
`default_nettype none

`include "n64_ppu_settings.svh"

package n64_ppu_pkg;

  // Color words
  typedef logic [`N64_COLOR_W-1:0] n64_color_t;
  typedef logic [`OUT_COLOR_W-1:0] out_color_t;

  // Sync nibble, all bits active low
  typedef logic [`SYNC_W-1:0] sync_t;

  // Gamma curve selection
  typedef logic [1:0] gamma_sel_t;

  // Field line counter
  typedef logic [`LINE_CNT_W-1:0] line_cnt_t;

  // AXI4-Lite vectors
  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;

  // Video demux FSM, named after the word expected next
  typedef enum logic [1:0] {
    DMX_SYNC,
    DMX_RED,
    DMX_GREEN,
    DMX_BLUE
  } demux_state_t;

  // AXI write channel FSM
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } axi_wr_state_t;

endpackage

`default_nettype wire

/* hdl/n64_pixel_if.sv */
// Demuxed pixel stream
`default_nettype none

interface n64_pixel_if
  import n64_ppu_pkg::*;
();

  // One-cycle strobe, no back-pressure
  logic       valid;
  sync_t      sync;
  n64_color_t red;
  n64_color_t green;
  n64_color_t blue;

  modport src (output valid, output sync, output red, output green, output blue);
  modport snk (input valid, input sync, input red, input green, input blue);

endinterface

`default_nettype wire

/* hdl/n64_cfg_regs.sv */
// PPU configuration registers
`default_nettype none

`include "n64_ppu_settings.svh"

module n64_cfg_regs
  import n64_ppu_pkg::*;
(
  input  logic       N64_CLK_i,
  input  logic       rst_n_i,
  input  axi_addr_t  s_axi_awaddr_i,
  input  logic       s_axi_awvalid_i,
  output logic       s_axi_awready_o,
  input  axi_data_t  s_axi_wdata_i,
  input  logic       s_axi_wvalid_i,
  output logic       s_axi_wready_o,
  output logic [1:0] s_axi_bresp_o,
  output logic       s_axi_bvalid_o,
  input  logic       s_axi_bready_i,
  input  axi_addr_t  s_axi_araddr_i,
  input  logic       s_axi_arvalid_i,
  output logic       s_axi_arready_o,
  output axi_data_t  s_axi_rdata_o,
  output logic [1:0] s_axi_rresp_o,
  output logic       s_axi_rvalid_o,
  input  logic       s_axi_rready_i,
  input  logic       pal_i,
  input  logic       interlaced_i,
  output gamma_sel_t gamma_sel_o,
  output logic       n16bit_mode_o
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  axi_wr_state_t wr_state_q;
  logic          wr_ready_q;
  logic          bvalid_q;
  logic [1:0]    bresp_q;
  logic          ar_ready_q;
  logic          rvalid_q;
  logic [1:0]    rresp_q;
  axi_data_t     rdata_q;
  logic [2:0]    cfg_q;
  axi_data_t     cfg_word;
  axi_data_t     status_word;
  logic          wr_addr_known;

  // Config is {n16bit_mode, gamma_sel}
  assign cfg_word    = {{(`AXI_DATA_W-3){1'b0}}, cfg_q};
  assign status_word = {{(`AXI_DATA_W-5){1'b0}}, cfg_q, interlaced_i, pal_i};

  // Status is read only, a write there is accepted and dropped
  assign wr_addr_known = (s_axi_awaddr_i == `REG_CFG_ADDR) ||
                         (s_axi_awaddr_i == `REG_STAT_ADDR);

  // ==================================================
  // Write channel
  // ==================================================

  // AW and W are taken together with one ready pulse
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_state_q <= WR_IDLE;
      wr_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      cfg_q      <= '0;
    end else begin
      wr_ready_q <= 1'b0;
      case (wr_state_q)
        WR_IDLE: begin
          if (wr_ready_q) begin
            wr_state_q <= WR_RESP;
            bvalid_q   <= 1'b1;
            if (s_axi_awaddr_i == `REG_CFG_ADDR) begin
              cfg_q <= s_axi_wdata_i[2:0];
            end
          end else if (s_axi_awvalid_i && s_axi_wvalid_i) begin
            wr_ready_q <= 1'b1;
          end
        end
        WR_RESP: begin
          if (s_axi_bready_i) begin
            bvalid_q   <= 1'b0;
            wr_state_q <= WR_IDLE;
          end
        end
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (wr_ready_q) begin
      bresp_q <= wr_addr_known ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ==================================================
  // Read channel
  // ==================================================

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ar_ready_q <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      ar_ready_q <= 1'b0;
      if (rvalid_q) begin
        if (s_axi_rready_i) begin
          rvalid_q <= 1'b0;
        end
      end else if (ar_ready_q) begin
        rvalid_q <= 1'b1;
      end else if (s_axi_arvalid_i) begin
        ar_ready_q <= 1'b1;
      end
    end
  end

  // Read data is captured in the address handshake cycle
  always_ff @(posedge N64_CLK_i) begin
    if (ar_ready_q) begin
      case (s_axi_araddr_i)
        `REG_CFG_ADDR: begin
          rdata_q <= cfg_word;
          rresp_q <= RESP_OKAY;
        end
        `REG_STAT_ADDR: begin
          rdata_q <= status_word;
          rresp_q <= RESP_OKAY;
        end
        default: begin
          rdata_q <= '0;
          rresp_q <= RESP_SLVERR;
        end
      endcase
    end
  end

  assign s_axi_awready_o = wr_ready_q;
  assign s_axi_wready_o  = wr_ready_q;
  assign s_axi_bvalid_o  = bvalid_q;
  assign s_axi_bresp_o   = bresp_q;
  assign s_axi_arready_o = ar_ready_q;
  assign s_axi_rvalid_o  = rvalid_q;
  assign s_axi_rdata_o   = rdata_q;
  assign s_axi_rresp_o   = rresp_q;

  assign gamma_sel_o   = cfg_q[1:0];
  assign n16bit_mode_o = cfg_q[2];

endmodule

`default_nettype wire

/* hdl/n64_vdemux.sv */
// N64 video bus demultiplexer
`default_nettype none

`include "n64_ppu_settings.svh"

module n64_vdemux
  import n64_ppu_pkg::*;
(
  input  logic       N64_CLK_i,
  input  logic       rst_n_i,
  input  logic       vdsync_n_i,
  input  n64_color_t vd_i,
  input  logic       n16bit_mode_i,
  n64_pixel_if.src   pix_o
);

  demux_state_t state_q;
  sync_t        sync_q;
  n64_color_t   red_q;
  n64_color_t   green_q;
  logic         pix_valid_q;
  sync_t        pix_sync_q;
  n64_color_t   pix_red_q;
  n64_color_t   pix_green_q;
  n64_color_t   pix_blue_q;

  // 16-bit mode drops the two color LSBs
  function automatic n64_color_t reduce_color(input n64_color_t c, input logic n16bit);
    reduce_color = n16bit ? {c[`N64_COLOR_W-1:2], 2'b00} : c;
  endfunction

  // A low nVDSYNC always restarts the word sequence
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= DMX_SYNC;
      pix_valid_q <= 1'b0;
    end else begin
      pix_valid_q <= 1'b0;
      if (!vdsync_n_i) begin
        state_q <= DMX_RED;
      end else begin
        case (state_q)
          DMX_RED:   state_q <= DMX_GREEN;
          DMX_GREEN: state_q <= DMX_BLUE;
          DMX_BLUE: begin
            state_q     <= DMX_SYNC;
            pix_valid_q <= 1'b1;
          end
          default:   state_q <= DMX_SYNC;
        endcase
      end
    end
  end

  // Word capture, pixel assembled when blue arrives
  always_ff @(posedge N64_CLK_i) begin
    if (!vdsync_n_i) begin
      sync_q <= vd_i[`SYNC_W-1:0];
    end else begin
      case (state_q)
        DMX_RED:   red_q   <= vd_i;
        DMX_GREEN: green_q <= vd_i;
        DMX_BLUE: begin
          pix_sync_q  <= sync_q;
          pix_red_q   <= reduce_color(red_q, n16bit_mode_i);
          pix_green_q <= reduce_color(green_q, n16bit_mode_i);
          pix_blue_q  <= reduce_color(vd_i, n16bit_mode_i);
        end
        default: ;
      endcase
    end
  end

  assign pix_o.valid = pix_valid_q;
  assign pix_o.sync  = pix_sync_q;
  assign pix_o.red   = pix_red_q;
  assign pix_o.green = pix_green_q;
  assign pix_o.blue  = pix_blue_q;

endmodule

`default_nettype wire

/* hdl/n64_vinfo.sv */
// Video info detection
`default_nettype none

`include "n64_ppu_settings.svh"

module n64_vinfo
  import n64_ppu_pkg::*;
(
  input  logic     N64_CLK_i,
  input  logic     rst_n_i,
  n64_pixel_if.snk pix_i,
  output logic     pal_o,
  output logic     interlaced_o
);

  sync_t     prev_sync_q;
  line_cnt_t line_cnt_q;
  line_cnt_t last_field_q;
  logic      hs_fall;
  logic      vs_fall;
  logic      pal_q;
  logic      interlaced_q;

  // Sync bits are active low, so a falling edge starts the pulse
  assign hs_fall = prev_sync_q[`SYNC_HS_BIT] & ~pix_i.sync[`SYNC_HS_BIT];
  assign vs_fall = prev_sync_q[`SYNC_VS_BIT] & ~pix_i.sync[`SYNC_VS_BIT];

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prev_sync_q  <= '1;
      line_cnt_q   <= '0;
      last_field_q <= '0;
      pal_q        <= 1'b0;
      interlaced_q <= 1'b0;
    end else if (pix_i.valid) begin
      prev_sync_q <= pix_i.sync;
      if (vs_fall) begin
        // Field complete, judge its length
        pal_q        <= line_cnt_q > `PAL_MIN_LINES;
        interlaced_q <= line_cnt_q != last_field_q;
        last_field_q <= line_cnt_q;
        line_cnt_q   <= hs_fall ? line_cnt_t'(1) : '0;
      end else if (hs_fall && (line_cnt_q != '1)) begin
        line_cnt_q <= line_cnt_q + 1'b1;
      end
    end
  end

  assign pal_o        = pal_q;
  assign interlaced_o = interlaced_q;

endmodule

`default_nettype wire

/* hdl/n64_gamma.sv */
// Gamma correction
`default_nettype none

`include "n64_ppu_settings.svh"

module n64_gamma
  import n64_ppu_pkg::*;
(
  input  logic       N64_CLK_i,
  input  logic       rst_n_i,
  input  gamma_sel_t gamma_sel_i,
  n64_pixel_if.snk   pix_i,
  output logic       pix_valid_o,
  output sync_t      sync_o,
  output out_color_t red_o,
  output out_color_t green_o,
  output out_color_t blue_o
);

  // One channel through the selected curve
  function automatic out_color_t apply_gamma(input gamma_sel_t sel, input n64_color_t c);
    logic [2*`N64_COLOR_W-1:0] sq;
    n64_color_t                inv;
    sq  = '0;
    inv = {`N64_COLOR_W{1'b1}} - c;
    case (sel)
      2'd1: begin
        // Darker, c^2 / 64
        sq          = c * c;
        apply_gamma = sq[2*`N64_COLOR_W-1 -: `OUT_COLOR_W];
      end
      2'd2: begin
        // Brighter, mirrored square
        sq          = inv * inv;
        apply_gamma = {`OUT_COLOR_W{1'b1}} - sq[2*`N64_COLOR_W-1 -: `OUT_COLOR_W];
      end
      default: apply_gamma = {c, c[`N64_COLOR_W-1]};
    endcase
  endfunction

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= pix_i.valid;
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (pix_i.valid) begin
      sync_o  <= pix_i.sync;
      red_o   <= apply_gamma(gamma_sel_i, pix_i.red);
      green_o <= apply_gamma(gamma_sel_i, pix_i.green);
      blue_o  <= apply_gamma(gamma_sel_i, pix_i.blue);
    end
  end

endmodule

`default_nettype wire

/* hdl/n64_ppu_top.sv */
// N64 PPU input stage top
`default_nettype none

module n64_ppu_top
  import n64_ppu_pkg::*;
(
  input  logic       N64_CLK_i,
  input  logic       rst_n_i,
  // Video bus
  input  logic       n64_vdsync_n_i,
  input  n64_color_t n64_vd_i,
  // AXI4-Lite
  input  axi_addr_t  s_axi_awaddr_i,
  input  logic       s_axi_awvalid_i,
  output logic       s_axi_awready_o,
  input  axi_data_t  s_axi_wdata_i,
  input  logic       s_axi_wvalid_i,
  output logic       s_axi_wready_o,
  output logic [1:0] s_axi_bresp_o,
  output logic       s_axi_bvalid_o,
  input  logic       s_axi_bready_i,
  input  axi_addr_t  s_axi_araddr_i,
  input  logic       s_axi_arvalid_i,
  output logic       s_axi_arready_o,
  output axi_data_t  s_axi_rdata_o,
  output logic [1:0] s_axi_rresp_o,
  output logic       s_axi_rvalid_o,
  input  logic       s_axi_rready_i,
  // Pixel outputs
  output logic       pix_valid_o,
  output sync_t      sync_o,
  output out_color_t red_o,
  output out_color_t green_o,
  output out_color_t blue_o,
  output logic       pal_o,
  output logic       interlaced_o
);

  gamma_sel_t gamma_sel;
  logic       n16bit_mode;

  n64_pixel_if i_pix_if ();

  // ==================================================
  // Configuration and status
  // ==================================================

  n64_cfg_regs i_n64_cfg_regs (
    .N64_CLK_i       (N64_CLK_i),
    .rst_n_i         (rst_n_i),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .pal_i           (pal_o),
    .interlaced_i    (interlaced_o),
    .gamma_sel_o     (gamma_sel),
    .n16bit_mode_o   (n16bit_mode)
  );

  // ==================================================
  // Video path
  // ==================================================

  n64_vdemux i_n64_vdemux (
    .N64_CLK_i     (N64_CLK_i),
    .rst_n_i       (rst_n_i),
    .vdsync_n_i    (n64_vdsync_n_i),
    .vd_i          (n64_vd_i),
    .n16bit_mode_i (n16bit_mode),
    .pix_o         (i_pix_if.src)
  );

  n64_vinfo i_n64_vinfo (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .pix_i        (i_pix_if.snk),
    .pal_o        (pal_o),
    .interlaced_o (interlaced_o)
  );

  n64_gamma i_n64_gamma (
    .N64_CLK_i   (N64_CLK_i),
    .rst_n_i     (rst_n_i),
    .gamma_sel_i (gamma_sel),
    .pix_i       (i_pix_if.snk),
    .pix_valid_o (pix_valid_o),
    .sync_o      (sync_o),
    .red_o       (red_o),
    .green_o     (green_o),
    .blue_o      (blue_o)
  );

endmodule

`default_nettype wire

/* sim/n64_ppu_checker.sv */
// PPU bound assertions
`default_nettype none

module n64_ppu_checker (
  input logic N64_CLK_i,
  input logic rst_n_i,
  input logic s_axi_bvalid_o,
  input logic s_axi_bready_i,
  input logic s_axi_rvalid_o,
  input logic s_axi_rready_i,
  input logic pix_valid_o
);

  // Response channels hold until the master takes them
  bvalid_hold: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o)
    else $error("rvalid dropped before rready");

  // A pixel takes four bus words, so strobes never touch
  pix_pacing: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    pix_valid_o |=> !pix_valid_o)
    else $error("pix_valid_o high in two consecutive cycles");

  reset_quiet: assert property (@(posedge N64_CLK_i)
    !rst_n_i |-> !pix_valid_o && !s_axi_bvalid_o && !s_axi_rvalid_o)
    else $error("Valid output high during reset");

endmodule

bind n64_ppu_top n64_ppu_checker i_n64_ppu_checker (
  .N64_CLK_i      (N64_CLK_i),
  .rst_n_i        (rst_n_i),
  .s_axi_bvalid_o (s_axi_bvalid_o),
  .s_axi_bready_i (s_axi_bready_i),
  .s_axi_rvalid_o (s_axi_rvalid_o),
  .s_axi_rready_i (s_axi_rready_i),
  .pix_valid_o    (pix_valid_o)
);

`default_nettype wire

/* sim/tb_n64_ppu.sv */
// N64 PPU testbench
`default_nettype none

`include "n64_ppu_settings.svh"

module tb_n64_ppu
  import n64_ppu_pkg::*;
();

  localparam int CLK_HALF   = 20;
  localparam int DRIVE_DLY  = 2;
  localparam int RST_CYCLES = 10;
  localparam int HS_TIMEOUT = 20;
  localparam int MAX_CMDS   = 64;
  localparam int CW         = `OUT_COLOR_W;
  localparam int ENTRY_W    = `SYNC_W + 3 * CW;

  // Sync nibbles, active low bits
  localparam sync_t SYNC_IDLE  = '1;
  localparam sync_t SYNC_LINE  = SYNC_IDLE & ~(sync_t'(1) << `SYNC_HS_BIT);
  localparam sync_t SYNC_FIELD = SYNC_LINE & ~(sync_t'(1) << `SYNC_VS_BIT);

  logic       N64_CLK_i;
  logic       rst_n_i;
  logic       n64_vdsync_n_i;
  n64_color_t n64_vd_i;
  axi_addr_t  s_axi_awaddr_i;
  logic       s_axi_awvalid_i;
  logic       s_axi_awready_o;
  axi_data_t  s_axi_wdata_i;
  logic       s_axi_wvalid_i;
  logic       s_axi_wready_o;
  logic [1:0] s_axi_bresp_o;
  logic       s_axi_bvalid_o;
  logic       s_axi_bready_i;
  axi_addr_t  s_axi_araddr_i;
  logic       s_axi_arvalid_i;
  logic       s_axi_arready_o;
  axi_data_t  s_axi_rdata_o;
  logic [1:0] s_axi_rresp_o;
  logic       s_axi_rvalid_o;
  logic       s_axi_rready_i;
  logic       pix_valid_o;
  sync_t      sync_o;
  out_color_t red_o;
  out_color_t green_o;
  out_color_t blue_o;
  logic       pal_o;
  logic       interlaced_o;

  // Expected pixels as {sync, red, green, blue}
  logic [ENTRY_W-1:0] exp_q[$];
  logic [ENTRY_W-1:0] exp_entry;
  logic [2:0]         cfg_model;
  logic [7:0]         cmd_kind [0:MAX_CMDS-1];
  int                 cmd_arg  [0:MAX_CMDS-1][0:6];
  int                 n_cmds;
  int                 budget_cycles;
  logic               budget_ready;

  n64_ppu_top i_n64_ppu_top (.*);

  always #CLK_HALF N64_CLK_i = ~N64_CLK_i;

  // ==================================================
  // Reporting and compare tasks
  // ==================================================

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_color(input string sig, input out_color_t exp, input out_color_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act));
    end
  endtask

  task automatic check_sync(input string sig, input sync_t exp, input sync_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act));
    end
  endtask

  task automatic check_flag(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED time=%0t %s expected=%b actual=%b", $time, sig, exp, act));
    end
  endtask

  task automatic check_axi_data(input string sig, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act));
    end
  endtask

  task automatic check_axi_resp(input string sig, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act));
    end
  endtask

  // Reference curves in integer arithmetic
  function automatic out_color_t expected_channel(input logic [2:0] cfg, input n64_color_t c);
    int v;
    int r;
    v = cfg[2] ? (int'(c) / 4) * 4 : int'(c);
    case (cfg[1:0])
      2'd1:    r = (v * v) / 64;
      2'd2:    r = 255 - ((127 - v) * (127 - v)) / 64;
      default: r = v * 2 + v / 64;
    endcase
    return out_color_t'(r);
  endfunction

  // ==================================================
  // Video bus
  // ==================================================

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge N64_CLK_i);
      waited++;
      if (waited > HS_TIMEOUT) begin
        stop_on_error("Expected pixels never appeared on pix_valid_o");
      end
    end
  endtask

  task automatic drive_pixel(input sync_t sync, input n64_color_t r, input n64_color_t g,
                             input n64_color_t b, input out_color_t exp_r,
                             input out_color_t exp_g, input out_color_t exp_b);
    exp_q.push_back({sync, exp_r, exp_g, exp_b});
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    n64_vdsync_n_i = 1'b0;
    n64_vd_i       = n64_color_t'(sync);
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    n64_vdsync_n_i = 1'b1;
    n64_vd_i       = r;
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    n64_vd_i = g;
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    n64_vd_i = b;
  endtask

  task automatic send_random_pixel(input sync_t sync);
    n64_color_t r;
    n64_color_t g;
    n64_color_t b;
    r = n64_color_t'($urandom);
    g = n64_color_t'($urandom);
    b = n64_color_t'($urandom);
    drive_pixel(sync, r, g, b, expected_channel(cfg_model, r),
                expected_channel(cfg_model, g), expected_channel(cfg_model, b));
  endtask

  // Idle pixel, two fields, then a closing vertical sync
  task automatic run_frame(input int lines0, input int lines1, input int ppl,
                           input logic exp_pal, input logic exp_il);
    int lines;
    send_random_pixel(SYNC_IDLE);
    for (int f = 0; f < 2; f++) begin
      lines = (f == 0) ? lines0 : lines1;
      for (int l = 0; l < lines; l++) begin
        for (int p = 0; p < ppl; p++) begin
          if (p != 0) begin
            send_random_pixel(SYNC_IDLE);
          end else if (l == 0) begin
            send_random_pixel(SYNC_FIELD);
          end else begin
            send_random_pixel(SYNC_LINE);
          end
        end
      end
    end
    send_random_pixel(SYNC_FIELD);
    wait_drain();
    check_flag("pal_o", exp_pal, pal_o);
    check_flag("interlaced_o", exp_il, interlaced_o);
  endtask

  // Every output pixel takes the oldest expected entry
  always @(negedge N64_CLK_i) begin
    if (rst_n_i && pix_valid_o) begin
      if (exp_q.size() == 0) begin
        stop_on_error("pix_valid_o pulsed while no pixel was expected");
      end else begin
        exp_entry = exp_q.pop_front();
        check_sync("sync_o", exp_entry[ENTRY_W-1 -: `SYNC_W], sync_o);
        check_color("red_o", exp_entry[3*CW-1 -: CW], red_o);
        check_color("green_o", exp_entry[2*CW-1 -: CW], green_o);
        check_color("blue_o", exp_entry[CW-1:0], blue_o);
      end
    end
  end

  // ==================================================
  // AXI4-Lite master
  // ==================================================

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                           input logic [1:0] exp_resp);
    int waited;
    wait_drain();
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    s_axi_awaddr_i  = addr;
    s_axi_awvalid_i = 1'b1;
    s_axi_wdata_i   = data;
    s_axi_wvalid_i  = 1'b1;
    waited = 0;
    do begin
      @(negedge N64_CLK_i);
      waited++;
      if (waited > HS_TIMEOUT) stop_on_error("AXI write was never accepted");
    end while (!s_axi_awready_o);
    check_flag("s_axi_wready_o", 1'b1, s_axi_wready_o);
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i  = 1'b0;
    waited = 0;
    do begin
      @(negedge N64_CLK_i);
      waited++;
      if (waited > HS_TIMEOUT) stop_on_error("AXI write response never arrived");
    end while (!s_axi_bvalid_o);
    check_axi_resp("s_axi_bresp_o", exp_resp, s_axi_bresp_o);
    // Hold bready off for a cycle so bvalid has to wait
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    s_axi_bready_i = 1'b1;
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    s_axi_bready_i = 1'b0;
    if (exp_resp == 2'b00 && addr == `REG_CFG_ADDR) begin
      cfg_model = data[2:0];
    end
  endtask

  task automatic axi_read(input axi_addr_t addr, input axi_data_t exp_data,
                          input logic [1:0] exp_resp);
    int waited;
    wait_drain();
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    s_axi_araddr_i  = addr;
    s_axi_arvalid_i = 1'b1;
    waited = 0;
    do begin
      @(negedge N64_CLK_i);
      waited++;
      if (waited > HS_TIMEOUT) stop_on_error("AXI read address was never accepted");
    end while (!s_axi_arready_o);
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    s_axi_arvalid_i = 1'b0;
    waited = 0;
    do begin
      @(negedge N64_CLK_i);
      waited++;
      if (waited > HS_TIMEOUT) stop_on_error("AXI read data never arrived");
    end while (!s_axi_rvalid_o);
    check_axi_data("s_axi_rdata_o", exp_data, s_axi_rdata_o);
    check_axi_resp("s_axi_rresp_o", exp_resp, s_axi_rresp_o);
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    s_axi_rready_i = 1'b1;
    @(posedge N64_CLK_i);
    #DRIVE_DLY;
    s_axi_rready_i = 1'b0;
  endtask

  // ==================================================
  // Stimulus file and run control
  // ==================================================

  task automatic load_stimulus();
    int         fd;
    int         n;
    string      line;
    logic [7:0] kind;
    fd = $fopen("sim/n64_ppu_stimulus.txt", "r");
    if (fd == 0) stop_on_error("Cannot open sim/n64_ppu_stimulus.txt");
    n_cmds        = 0;
    budget_cycles = RST_CYCLES + 8;
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%c", kind);
      if (n == 1 && (kind == "W" || kind == "R")) begin
        n = $sscanf(line, "%c %h %h %h", kind, cmd_arg[n_cmds][0], cmd_arg[n_cmds][1],
                    cmd_arg[n_cmds][2]);
        if (n != 4) stop_on_error("Malformed register line in stimulus file");
        budget_cycles += 24;
      end else if (n == 1 && kind == "P") begin
        n = $sscanf(line, "%c %h %h %h %h %h %h %h", kind, cmd_arg[n_cmds][0],
                    cmd_arg[n_cmds][1], cmd_arg[n_cmds][2], cmd_arg[n_cmds][3],
                    cmd_arg[n_cmds][4], cmd_arg[n_cmds][5], cmd_arg[n_cmds][6]);
        if (n != 8) stop_on_error("Malformed pixel line in stimulus file");
        budget_cycles += 8;
      end else if (n == 1 && kind == "F") begin
        n = $sscanf(line, "%c %d %d %d %d %d", kind, cmd_arg[n_cmds][0], cmd_arg[n_cmds][1],
                    cmd_arg[n_cmds][2], cmd_arg[n_cmds][3], cmd_arg[n_cmds][4]);
        if (n != 6) stop_on_error("Malformed frame line in stimulus file");
        budget_cycles += (cmd_arg[n_cmds][0] + cmd_arg[n_cmds][1]) * cmd_arg[n_cmds][2] * 4;
        budget_cycles += 16;
      end else begin
        continue;
      end
      if (n_cmds == MAX_CMDS - 1) stop_on_error("Too many commands in stimulus file");
      cmd_kind[n_cmds] = kind;
      n_cmds++;
    end
    $fclose(fd);
  endtask

  // Watchdog, twice the expected run length
  initial begin
    wait (budget_ready === 1'b1);
    repeat (2 * budget_cycles) @(posedge N64_CLK_i);
    stop_on_error($sformatf("Watchdog expired after %0d cycles", 2 * budget_cycles));
  end

  initial begin
    void'($urandom(32'h4e76));
    N64_CLK_i       = 1'b0;
    rst_n_i         = 1'b0;
    n64_vdsync_n_i  = 1'b1;
    n64_vd_i        = '0;
    s_axi_awaddr_i  = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i   = '0;
    s_axi_wvalid_i  = 1'b0;
    s_axi_bready_i  = 1'b0;
    s_axi_araddr_i  = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b0;
    cfg_model       = '0;
    budget_ready    = 1'b0;
    load_stimulus();
    budget_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge N64_CLK_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    for (int i = 0; i < n_cmds; i++) begin
      case (cmd_kind[i])
        "W": axi_write(axi_addr_t'(cmd_arg[i][0]), axi_data_t'(cmd_arg[i][1]),
                       2'(cmd_arg[i][2]));
        "R": axi_read(axi_addr_t'(cmd_arg[i][0]), axi_data_t'(cmd_arg[i][1]),
                      2'(cmd_arg[i][2]));
        "P": drive_pixel(sync_t'(cmd_arg[i][0]), n64_color_t'(cmd_arg[i][1]),
                         n64_color_t'(cmd_arg[i][2]), n64_color_t'(cmd_arg[i][3]),
                         out_color_t'(cmd_arg[i][4]), out_color_t'(cmd_arg[i][5]),
                         out_color_t'(cmd_arg[i][6]));
        "F": run_frame(cmd_arg[i][0], cmd_arg[i][1], cmd_arg[i][2], cmd_arg[i][3] != 0,
                       cmd_arg[i][4] != 0);
        default: ;
      endcase
    end
    wait_drain();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/n64_ppu_stimulus.txt */
# W or R addr data resp (hex), P sync red green blue exp_red exp_green exp_blue (hex)
# F field0_lines field1_lines pixels_per_line pal interlaced (decimal)
R 4 00000000 0
R 0 00000000 0
W 0 00000005 0
R 0 00000005 0
W 9 00000002 2
R 0 00000005 0
R c 00000000 2
W 0 00000000 0
P f 00 7f 40 00 ff 81
P d 01 3f 55 02 7e ab
P 7 7e 2a 15 fd 54 2a
W 0 00000004 0
P 5 7f 43 1a f9 81 30
W 0 00000001 0
F 263 263 2 0 0
R 4 00000004 0
W 0 00000002 0
F 263 262 2 0 1
R 4 0000000a 0
W 0 00000007 0
F 313 312 2 1 1
R 4 0000001f 0

/* n64_ppu_top.f */
+incdir+include
hdl/n64_ppu_pkg.sv
hdl/n64_pixel_if.sv
hdl/n64_cfg_regs.sv
hdl/n64_vdemux.sv
hdl/n64_vinfo.sv
hdl/n64_gamma.sv
hdl/n64_ppu_top.sv
sim/n64_ppu_checker.sv
sim/tb_n64_ppu.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_n64_ppu
FILELIST := n64_ppu_top.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := SIMULATION PASSED

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
